//--- Bender.yml
package:
  name: nes_pad_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/nes_pad_pkg.sv
      - verilog/pad_report_if.sv
      - verilog/nes_pad_scanner.sv
      - verilog/poll_timer.sv
      - verilog/nes_pad_regs.sv
      - verilog/nes_pad_ctrl.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/nes_pad_model.sv
      - testbench/tb_nes_pad_ctrl.sv

//--- nes_pad_ctrl.f
+incdir+verilog
verilog/nes_pad_pkg.sv
verilog/pad_report_if.sv
verilog/nes_pad_scanner.sv
verilog/poll_timer.sv
verilog/nes_pad_regs.sv
verilog/nes_pad_ctrl.sv
testbench/nes_pad_model.sv
testbench/tb_nes_pad_ctrl.sv

//--- testbench/nes_pad_model.sv
`timescale 1ns/1ps

// Two NES pads on a shared latch and clock, each an 8-bit parallel-in shift register
module nes_pad_model (
	input  logic [7:0] buttons0,                                 // Pad 0, 1 = pressed
	input  logic [7:0] buttons1,                                 // Pad 1, 1 = pressed
	input  logic       nes_latch,
	input  logic       nes_clk,
	output logic       nes_data0,
	output logic       nes_data1
);

	logic [7:0] sr0 = 8'hff;                                     // Released pad reads all ones
	logic [7:0] sr1 = 8'hff;

	// Latch loads the buttons, each rising pad clock moves the next one out
	always @(posedge nes_clk or posedge nes_latch)
	begin
		if (nes_latch)
		begin
			sr0 <= ~buttons0;                                    // Pad drives 0 for pressed
			sr1 <= ~buttons1;
		end
		else
		begin
			sr0 <= {sr0[6:0], 1'b1};                             // Ones after the last button
			sr1 <= {sr1[6:0], 1'b1};
		end
	end

	assign nes_data0 = sr0[7];                                   // A comes out first
	assign nes_data1 = sr1[7];

endmodule

//--- testbench/tb_nes_pad_ctrl.sv
`timescale 1ns/1ps
`include "nes_pad_settings.svh"

module tb_nes_pad_ctrl
	import nes_pad_pkg::*;
();

	localparam int CLK_NS      = 4;
	localparam int NUM_ROWS    = 8;
	localparam int SCAN_NS     = 19 * `NES_BIT_DIV * CLK_NS;     // 19 steps per scan
	localparam int WATCHDOG_NS = NUM_ROWS * SCAN_NS * 4;
	localparam int ACK_LIMIT   = 8;                              // clk cycles to wait for ack
	localparam wb_data_t AUTO_PERIOD = 16'd400;                  // Longer than one scan

	logic      clk;
	logic      reset_n;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	reg_addr_t wb_adr;
	wb_data_t  wb_dat_w;
	wb_data_t  wb_dat_r;
	logic      wb_ack;
	logic      nes_latch;
	logic      nes_clk;
	logic      nes_data0;
	logic      nes_data1;
	pad_byte_t btn0;                                             // Buttons held by the pad model
	pad_byte_t btn1;
	int        errors;
	int        checks;

	string     row_name [NUM_ROWS];
	pad_byte_t row_pad0 [NUM_ROWS];
	pad_byte_t row_pad1 [NUM_ROWS];
	logic      row_auto [NUM_ROWS];                              // 1 auto-poll, 0 manual trigger
	logic      row_rdp  [NUM_ROWS];                              // 1 read and clear PRESSED

	nes_pad_ctrl nes_pad_ctrl_inst (
		.clk       (clk),
		.reset_n   (reset_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.nes_latch (nes_latch),
		.nes_clk   (nes_clk),
		.nes_data0 (nes_data0),
		.nes_data1 (nes_data1)
	);

	nes_pad_model model_inst (
		.buttons0  (btn0),
		.buttons1  (btn1),
		.nes_latch (nes_latch),
		.nes_clk   (nes_clk),
		.nes_data0 (nes_data0),
		.nes_data1 (nes_data1)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS);
		$display("=== FAIL ===");
		$finish;
	end

	// One classic cycle, driven on the falling edge and held until ack
	task automatic bus_cycle(input logic we, input reg_addr_t addr, input wb_data_t wdata,
		output wb_data_t rdata);
		int waited;
		waited = 0;
		@(negedge clk);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = addr;
		wb_dat_w = wdata;
		@(negedge clk);
		while (!wb_ack && waited < ACK_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		rdata = wb_dat_r;                                        // Valid while ack is high
		assert (wb_ack)
		else
		begin
			errors++;
			$display("no Wishbone ack from address %0d", addr);
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic write_reg(input reg_addr_t addr, input wb_data_t data);
		wb_data_t unused;
		bus_cycle(1'b1, addr, data, unused);
	endtask

	task automatic fetch_reg(input reg_addr_t addr, output wb_data_t data);
		bus_cycle(1'b0, addr, '0, data);
	endtask

	task automatic compare_value(input string test, input string what, input wb_data_t expected,
		input wb_data_t actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("mismatch %s %s: expected 0x%04h actual 0x%04h", test, what, expected, actual);
		end
	endtask

	// Polls STATUS until new data is seen and cleared by the same read
	task automatic await_new_data(input string test);
		wb_data_t status;
		time      t0;
		t0     = $time;
		status = '0;
		while (!status[STAT_NEW_BIT] && ($time - t0) < 4 * SCAN_NS)
			fetch_reg(REG_STATUS, status);
		assert (status[STAT_NEW_BIT])
		else
		begin
			errors++;
			$display("timeout in %s: no new data arrived", test);
		end
	endtask

	// Lets a running scan finish, then clears the flag its done may have set
	task automatic drain_scanner();
		wb_data_t status;
		fetch_reg(REG_STATUS, status);
		while (status[STAT_BUSY_BIT])
			fetch_reg(REG_STATUS, status);
		fetch_reg(REG_STATUS, status);
	endtask

	task automatic set_row(input int idx, input string name, input pad_byte_t p0,
		input pad_byte_t p1, input logic auto_mode, input logic read_pressed);
		row_name[idx] = name;
		row_pad0[idx] = p0;
		row_pad1[idx] = p1;
		row_auto[idx] = auto_mode;
		row_rdp[idx]  = read_pressed;
	endtask

	task automatic fill_table();
		set_row(0, "a_and_right", 8'h80, 8'h01, 1'b0, 1'b1);     // A at bit 7, Right at bit 0
		set_row(1, "mixed", 8'ha5, 8'h5a, 1'b0, 1'b1);
		set_row(2, "release_all", 8'h00, 8'h00, 1'b0, 1'b0);
		set_row(3, "accum_first", 8'h81, 8'h18, 1'b0, 1'b0);     // PRESSED left unread
		set_row(4, "accum_second", 8'hc3, 8'h3c, 1'b0, 1'b1);    // Both scans show up here
		set_row(5, "auto_poll", 8'($urandom), 8'($urandom), 1'b1, 1'b1);
		set_row(6, "random_manual", 8'($urandom), 8'($urandom), 1'b0, 1'b1);
		set_row(7, "auto_random", 8'($urandom), 8'($urandom), 1'b1, 1'b0);
	endtask

	initial
	begin
		int unsigned rnd_seed;
		wb_data_t    rdata;
		pad_byte_t   prev0;
		pad_byte_t   prev1;
		pad_byte_t   acc0;
		pad_byte_t   acc1;
		rnd_seed = 32'hc661_732a;
		rnd_seed = $urandom(rnd_seed);
		errors   = 0;
		checks   = 0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		btn0     = '0;
		btn1     = '0;
		reset_n  = 1'b0;
		fill_table();
		repeat (3) @(negedge clk);
		compare_value("reset", "nes_clk", 16'd1, wb_data_t'(nes_clk));     // Pins at reset level
		compare_value("reset", "nes_latch", 16'd0, wb_data_t'(nes_latch));
		reset_n = 1'b1;

		for (int a = 0; a < `NES_REG_COUNT; a++)
		begin
			fetch_reg(reg_addr_t'(a), rdata);
			compare_value("reset", $sformatf("addr %0d", a), '0, rdata);
		end

		write_reg(REG_POLL_PERIOD, 16'h1234);
		fetch_reg(REG_POLL_PERIOD, rdata);
		compare_value("readback", "POLL_PERIOD", 16'h1234, rdata);
		write_reg(REG_CTRL, 16'h0001);
		fetch_reg(REG_CTRL, rdata);
		compare_value("readback", "CTRL", 16'h0001, rdata);
		write_reg(REG_CTRL, 16'h0000);                           // Off long before the period ends
		write_reg(reg_addr_t'(7), 16'hffff);
		fetch_reg(reg_addr_t'(7), rdata);
		compare_value("readback", "addr 7", 16'h0000, rdata);
		write_reg(REG_POLL_PERIOD, AUTO_PERIOD);

		prev0 = '0;
		prev1 = '0;
		acc0  = '0;
		acc1  = '0;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			@(negedge clk);
			btn0  = row_pad0[r];
			btn1  = row_pad1[r];
			acc0  = acc0 | (row_pad0[r] & ~prev0);               // Rising buttons since last read
			acc1  = acc1 | (row_pad1[r] & ~prev1);
			prev0 = row_pad0[r];
			prev1 = row_pad1[r];
			if (row_auto[r])
			begin
				write_reg(REG_CTRL, 16'h0001);
				await_new_data(row_name[r]);
				await_new_data(row_name[r]);                     // Flag sets again after the read
				write_reg(REG_CTRL, 16'h0000);
				drain_scanner();
			end
			else
			begin
				write_reg(REG_CTRL, 16'h0002);
				fetch_reg(REG_STATUS, rdata);
				compare_value(row_name[r], "STATUS after trigger", 16'h0001, rdata);
				await_new_data(row_name[r]);
			end
			fetch_reg(REG_PAD0, rdata);
			compare_value(row_name[r], "PAD0", wb_data_t'(row_pad0[r]), rdata);
			fetch_reg(REG_PAD1, rdata);
			compare_value(row_name[r], "PAD1", wb_data_t'(row_pad1[r]), rdata);
			if (row_rdp[r])
			begin
				fetch_reg(REG_PRESSED0, rdata);
				compare_value(row_name[r], "PRESSED0", wb_data_t'(acc0), rdata);
				fetch_reg(REG_PRESSED0, rdata);
				compare_value(row_name[r], "PRESSED0 reread", '0, rdata);
				fetch_reg(REG_PRESSED1, rdata);
				compare_value(row_name[r], "PRESSED1", wb_data_t'(acc1), rdata);
				fetch_reg(REG_PRESSED1, rdata);
				compare_value(row_name[r], "PRESSED1 reread", '0, rdata);
				acc0 = '0;
				acc1 = '0;
			end
		end

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- verilog/nes_pad_ctrl.sv
`timescale 1ns/1ps
`include "nes_pad_settings.svh"

module nes_pad_ctrl
	import nes_pad_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	// Wishbone classic slave
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  logic      wb_we,
	input  reg_addr_t wb_adr,
	input  wb_data_t  wb_dat_w,
	output wb_data_t  wb_dat_r,
	output logic      wb_ack,
	// NES pad pins, shared latch and clock
	output logic      nes_latch,
	output logic      nes_clk,
	input  logic      nes_data0,
	input  logic      nes_data1
);

	logic                   auto_en;                             // From CTRL
	logic [`NES_POLL_W-1:0] poll_period;                         // From POLL_PERIOD
	logic                   manual_trig;                         // Pulse from CTRL write

	pad_report_if rep_if ();

	poll_timer poll_timer_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.auto_en     (auto_en),
		.poll_period (poll_period),
		.manual_trig (manual_trig),
		.rep         (rep_if.ctrl)
	);

	nes_pad_scanner nes_pad_scanner_inst (
		.clk       (clk),
		.reset_n   (reset_n),
		.rep       (rep_if.scan),
		.nes_latch (nes_latch),
		.nes_clk   (nes_clk),
		.nes_data0 (nes_data0),
		.nes_data1 (nes_data1)
	);

	nes_pad_regs nes_pad_regs_inst (
		.clk         (clk),
		.reset_n     (reset_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.rep         (rep_if.sink),
		.auto_en     (auto_en),
		.poll_period (poll_period),
		.manual_trig (manual_trig)
	);

endmodule

//--- verilog/nes_pad_pkg.sv
`include "nes_pad_settings.svh"

package nes_pad_pkg;

	typedef logic [7:0] pad_byte_t;                              // Bit 7 A ... bit 0 Right, 1 = pressed
	typedef logic [15:0] wb_data_t;                              // Wishbone data word
	typedef logic [$clog2(`NES_REG_COUNT)-1:0] reg_addr_t;       // Word address

	// Scanner sequence, one step per divider wrap
	typedef enum logic [2:0] {
		SCAN_IDLE     = 3'd0,                                    // Waiting for start
		SCAN_LATCH_HI = 3'd1,                                    // Pads load their buttons
		SCAN_LATCH_LO = 3'd2,                                    // Latch released, A on data line
		SCAN_CLOCK_LO = 3'd3,                                    // Sample data line
		SCAN_CLOCK_HI = 3'd4,                                    // Pad shifts on rising edge
		SCAN_DONE     = 3'd5                                     // Report both bytes
	} scan_state_t;

	// Register map
	localparam reg_addr_t REG_CTRL        = 3'd0;                // Auto-poll enable, manual trigger
	localparam reg_addr_t REG_POLL_PERIOD = 3'd1;                // Auto-poll period in clk cycles
	localparam reg_addr_t REG_STATUS      = 3'd2;                // Busy, new data
	localparam reg_addr_t REG_PAD0        = 3'd3;                // Last report of pad 0
	localparam reg_addr_t REG_PAD1        = 3'd4;                // Last report of pad 1
	localparam reg_addr_t REG_PRESSED0    = 3'd5;                // Newly pressed on pad 0
	localparam reg_addr_t REG_PRESSED1    = 3'd6;                // Newly pressed on pad 1

	// Bit positions inside CTRL and STATUS
	localparam int CTRL_AUTO_BIT = 0;                            // Auto-poll enable
	localparam int CTRL_TRIG_BIT = 1;                            // Manual trigger, self-clearing
	localparam int STAT_BUSY_BIT = 0;                            // Scan in progress
	localparam int STAT_NEW_BIT  = 1;                            // Fresh report, clears on read

endpackage

//--- verilog/nes_pad_regs.sv
`timescale 1ns/1ps
`include "nes_pad_settings.svh"

module nes_pad_regs
	import nes_pad_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  reg_addr_t              wb_adr,
	input  wb_data_t               wb_dat_w,
	output wb_data_t               wb_dat_r,
	output logic                   wb_ack,
	pad_report_if.sink             rep,
	output logic                   auto_en,
	output logic [`NES_POLL_W-1:0] poll_period,
	output logic                   manual_trig
);

	logic      access;                                           // Bus cycle not yet acked
	logic      wr_en;
	logic      rd_en;
	logic      new_data;                                         // Report not yet seen by host
	pad_byte_t scan_byte [2];                                    // Bytes from scanner
	pad_byte_t pad_q [2];                                        // Last complete report
	pad_byte_t pressed_q [2];                                    // Rising buttons since last read
	wb_data_t  rd_mux;

	assign access = wb_cyc && wb_stb && !wb_ack;
	assign wr_en  = access && wb_we;
	assign rd_en  = access && !wb_we;

	assign scan_byte[0] = rep.pad0;
	assign scan_byte[1] = rep.pad1;

	// Ack one clk after the request, low again for the next cycle
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= access;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			auto_en     <= 1'b0;
			poll_period <= '0;
			manual_trig <= 1'b0;
		end
		else
		begin
			manual_trig <= wr_en && (wb_adr == REG_CTRL) && wb_dat_w[CTRL_TRIG_BIT];
			if (wr_en && wb_adr == REG_CTRL)
				auto_en <= wb_dat_w[CTRL_AUTO_BIT];
			if (wr_en && wb_adr == REG_POLL_PERIOD)
				poll_period <= wb_dat_w[`NES_POLL_W-1:0];
		end
	end

	// Done has priority over the clear-on-read
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			new_data <= 1'b0;
		else if (rep.done)
			new_data <= 1'b1;
		else if (rd_en && wb_adr == REG_STATUS)
			new_data <= 1'b0;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			for (int i = 0; i < 2; i++)
			begin
				pad_q[i]     <= '0;
				pressed_q[i] <= '0;
			end
		end
		else if (rep.done)
		begin
			for (int i = 0; i < 2; i++)
			begin
				pad_q[i]     <= scan_byte[i];
				pressed_q[i] <= pressed_q[i] | (scan_byte[i] & ~pad_q[i]); // New rising edges
			end
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (rd_en && wb_adr == reg_addr_t'(REG_PRESSED0 + i))
					pressed_q[i] <= '0;                          // Host has seen them
			end
		end
	end

	always_comb
	begin
		rd_mux = '0;
		case (wb_adr)
			REG_CTRL:        rd_mux[CTRL_AUTO_BIT] = auto_en;    // Trigger bit reads 0
			REG_POLL_PERIOD: rd_mux = wb_data_t'(poll_period);
			REG_STATUS:
			begin
				rd_mux[STAT_BUSY_BIT] = rep.busy;
				rd_mux[STAT_NEW_BIT]  = new_data;
			end
			REG_PAD0:        rd_mux = wb_data_t'(pad_q[0]);
			REG_PAD1:        rd_mux = wb_data_t'(pad_q[1]);
			REG_PRESSED0:    rd_mux = wb_data_t'(pressed_q[0]);
			REG_PRESSED1:    rd_mux = wb_data_t'(pressed_q[1]);
			default:         rd_mux = '0;                        // Unused address
		endcase
	end

	// Captured with the access, valid while ack is high
	always_ff @(posedge clk)
	begin
		if (rd_en)
			wb_dat_r <= rd_mux;
	end

endmodule

//--- verilog/nes_pad_scanner.sv
`timescale 1ns/1ps
`include "nes_pad_settings.svh"

module nes_pad_scanner
	import nes_pad_pkg::*;
(
	input  logic       clk,
	input  logic       reset_n,
	pad_report_if.scan rep,
	output logic       nes_latch,
	output logic       nes_clk,
	input  logic       nes_data0,
	input  logic       nes_data1
);

	localparam int DIV_W = $clog2(`NES_BIT_DIV);

	logic [DIV_W-1:0] div_cnt;                                   // Free-running step divider
	logic             step_en;                                   // One clk per scanner step
	logic             start_pend;                                // Sticky start request
	logic             busy_q;
	logic             done_q;
	logic [2:0]       bit_cnt;                                   // Button index
	scan_state_t      state;
	scan_state_t      next_state;
	pad_byte_t        shift0;                                    // Pad 0 shift register
	pad_byte_t        shift1;                                    // Pad 1 shift register

	// Divider wraps every NES_BIT_DIV clocks, independent of scans
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			div_cnt <= '0;
		else if (step_en)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign step_en = (div_cnt == DIV_W'(`NES_BIT_DIV - 1));

	// Start is caught here since it may arrive between steps
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			start_pend <= 1'b0;
			busy_q     <= 1'b0;
		end
		else if (rep.start && !busy_q)
		begin
			start_pend <= 1'b1;                                  // Held until sequence leaves IDLE
			busy_q     <= 1'b1;
		end
		else
		begin
			if (state != SCAN_IDLE)
				start_pend <= 1'b0;
			if (step_en && state == SCAN_DONE)
				busy_q <= 1'b0;                                  // Falls together with done
		end
	end

	always_comb
	begin
		case (state)
			SCAN_IDLE:     next_state = start_pend ? SCAN_LATCH_HI : SCAN_IDLE;
			SCAN_LATCH_HI: next_state = SCAN_LATCH_LO;
			SCAN_LATCH_LO: next_state = SCAN_CLOCK_LO;
			SCAN_CLOCK_LO: next_state = SCAN_CLOCK_HI;
			SCAN_CLOCK_HI: next_state = (&bit_cnt) ? SCAN_DONE : SCAN_CLOCK_LO;
			default:       next_state = SCAN_IDLE;               // DONE and unused codes
		endcase
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state   <= SCAN_IDLE;
			bit_cnt <= 3'd0;
			done_q  <= 1'b0;
		end
		else
		begin
			done_q <= step_en && (state == SCAN_DONE);           // Single clk pulse
			if (step_en)
			begin
				state <= next_state;
				if (state == SCAN_CLOCK_HI)
					bit_cnt <= bit_cnt + 3'd1;                   // Wraps to 0 after last button
			end
		end
	end

	// Pad pins are registered so they never glitch
	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			nes_latch <= 1'b0;
			nes_clk   <= 1'b1;                                   // Idle high
		end
		else
		begin
			nes_latch <= (state == SCAN_LATCH_HI);
			nes_clk   <= (state != SCAN_CLOCK_LO);
		end
	end

	// Sample at end of clock-low step, pad shifts one clk later on rising nes_clk
	always_ff @(posedge clk)
	begin
		if (step_en && state == SCAN_CLOCK_LO)
		begin
			shift0 <= {shift0[6:0], ~nes_data0};                 // Pad drives 0 for pressed
			shift1 <= {shift1[6:0], ~nes_data1};                 // A lands in bit 7
		end
	end

	assign rep.busy = busy_q;
	assign rep.done = done_q;
	assign rep.pad0 = shift0;                                    // Stable while idle
	assign rep.pad1 = shift1;

endmodule

//--- verilog/nes_pad_settings.svh
`ifndef NES_PAD_SETTINGS_SVH
`define NES_PAD_SETTINGS_SVH

// clk cycles per scanner step
// At 16 the pad clock stays under 1.5 MHz for clk up to 48 MHz
`define NES_BIT_DIV 16

// Width of the auto-poll period counter and POLL_PERIOD register
`define NES_POLL_W 16

// Number of word registers in the host map
`define NES_REG_COUNT 8

`endif

//--- verilog/pad_report_if.sv
`timescale 1ns/1ps

// Links poll timer, scanner and register block
interface pad_report_if
	import nes_pad_pkg::*;
();

	logic      start;                                            // One-clock scan request
	logic      busy;                                             // Scan in progress
	logic      done;                                             // One-clock end of scan
	pad_byte_t pad0;                                             // Pad 0 buttons, valid with done
	pad_byte_t pad1;                                             // Pad 1 buttons, valid with done

	// Poll timer side
	modport ctrl (
		output start,
		input  busy
	);

	// Scanner side
	modport scan (
		input  start,
		output busy,
		output done,
		output pad0,
		output pad1
	);

	// Register block side, busy feeds STATUS
	modport sink (
		input  busy,
		input  done,
		input  pad0,
		input  pad1
	);

endinterface

//--- verilog/poll_timer.sv
`timescale 1ns/1ps
`include "nes_pad_settings.svh"

module poll_timer (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   auto_en,
	input  logic [`NES_POLL_W-1:0] poll_period,
	input  logic                   manual_trig,
	pad_report_if.ctrl             rep
);

	logic [`NES_POLL_W-1:0] period_cnt;                          // clk cycles since last start
	logic                   period_hit;                          // Auto-poll period reached
	logic                   req_new;                             // Request raised this clk
	logic                   req_pend;                            // Request waiting for idle scanner
	logic                   fire;

	// Counter saturates at the period, so the hit holds while scanner is busy
	assign period_hit = auto_en && (period_cnt == poll_period - 1'b1);
	assign req_new    = period_hit || manual_trig;
	assign fire       = (req_pend || req_new) && !rep.busy;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			period_cnt <= '0;
		else if (!auto_en || fire)
			period_cnt <= '0;                                    // Restart from each start
		else if (!period_hit)
			period_cnt <= period_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			req_pend <= 1'b0;
		else if (fire)
			req_pend <= 1'b0;
		else if (req_new)
			req_pend <= 1'b1;                                    // Held until busy falls
	end

	// Scanner raises busy on the next clk, so this is one clk wide
	assign rep.start = fire;

endmodule
